// File: hdl/move_result.sv
module move_result
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              move_done,
  input  logic [STEP_W-1:0] applied_step,
  input  logic              blocked,
  input  logic              busy,
  input  logic [3:0]        obstacles,
  input  logic [DIST_W-1:0] dist_up,
  input  logic [DIST_W-1:0] dist_down,
  input  logic [DIST_W-1:0] dist_left,
  input  logic [DIST_W-1:0] dist_right,
  input  logic [X_W-1:0]    player_x,
  input  logic [Y_W-1:0]    player_y,
  input  logic [TILE_W-1:0] map_rdata,
  input  reg_sel_t          rd_sel,
  output logic [WB_DW-1:0]  rd_data
);

  logic [STEP_W-1:0] last_step;
  logic              last_blocked;
  logic [7:0]        move_cnt;
  logic [7:0]        blk_cnt;

  // Both counters wrap at 256
  always_ff @(posedge clk) begin
    if (rst) begin
      last_step    <= '0;
      last_blocked <= 1'b0;
      move_cnt     <= '0;
      blk_cnt      <= '0;
    end else if (move_done) begin
      last_step    <= applied_step;
      last_blocked <= blocked;
      move_cnt     <= move_cnt + 1'b1;
      blk_cnt      <= blk_cnt + 8'(blocked);
    end
  end

  // ==============================
  // Read word packing
  // ==============================
  always_comb begin
    case (rd_sel)
      REG_POS:    rd_data = {6'd0, player_y, 5'd0, player_x};
      REG_MOVE:   rd_data = {18'd0, last_step, 8'd0};
      REG_STATUS: rd_data = {move_cnt, blk_cnt, 2'd0, last_step, 2'd0,
                             last_blocked, busy, obstacles};
      REG_DIST:   rd_data = {1'b0, dist_right, 1'b0, dist_left,
                             1'b0, dist_down, 1'b0, dist_up};
      REG_MAP:    rd_data = WB_DW'(map_rdata);
      default:    rd_data = '0;
    endcase
  end

endmodule

// File: hdl/obstacle_scan.sv
module obstacle_scan
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [X_W-1:0]    player_x,
  input  logic [Y_W-1:0]    player_y,
  output logic [MAP_AW-1:0] scan_addr,
  input  logic [TILE_W-1:0] scan_data,
  output logic [3:0]        obstacles,
  output logic [DIST_W-1:0] dist_up,
  output logic [DIST_W-1:0] dist_down,
  output logic [DIST_W-1:0] dist_left,
  output logic [DIST_W-1:0] dist_right,
  output logic              scan_fresh
);

  // ==============================
  // Tile position of the top-left corner
  // ==============================
  logic [ROW_W-1:0]  row;
  logic [COL_W-1:0]  col;
  logic [MAP_AW-1:0] base;
  logic [3:0]        at_edge;
  logic [3:0]        touch;
  logic [DIST_W-1:0] rem [4];
  logic [DIST_W-1:0] off_x;
  logic [DIST_W-1:0] off_y;
  logic [DIST_W-1:0] right_end;
  logic [DIST_W-1:0] bottom_end;

  assign row  = player_y[Y_W-1:TILE_SHIFT];
  assign col  = player_x[X_W-1:TILE_SHIFT];
  assign base = MAP_AW'(row) * MAP_AW'(NUM_COL) + MAP_AW'(col);

  always_comb begin
    // Map edges stop the sprite and keep the neighbour address in range
    at_edge[DIR_UP]    = (row == '0);
    at_edge[DIR_DOWN]  = (row >= ROW_W'(NUM_ROW - 1));
    at_edge[DIR_LEFT]  = (col == '0);
    at_edge[DIR_RIGHT] = (col >= COL_W'(NUM_COL - 1));

    off_x      = DIST_W'(player_x[TILE_SHIFT-1:0]);
    off_y      = DIST_W'(player_y[TILE_SHIFT-1:0]);
    right_end  = off_x + DIST_W'(SPRITE_W);
    bottom_end = off_y + DIST_W'(SPRITE_H);

    // The sprite sits right against the boundary of its tile
    touch[DIR_UP]    = (off_y == '0);
    touch[DIR_DOWN]  = (bottom_end == DIST_W'(TILE_PX));
    touch[DIR_LEFT]  = (off_x == '0);
    touch[DIR_RIGHT] = (right_end == DIST_W'(TILE_PX));

    // Pixels left before the sprite reaches that boundary
    rem[DIR_UP]    = off_y;
    rem[DIR_LEFT]  = off_x;
    rem[DIR_DOWN]  = (bottom_end >= DIST_W'(TILE_PX)) ? '0 : DIST_W'(TILE_PX) - bottom_end;
    rem[DIR_RIGHT] = (right_end >= DIST_W'(TILE_PX)) ? '0 : DIST_W'(TILE_PX) - right_end;
  end

  // ==============================
  // Restart on position change
  // ==============================
  logic [X_W-1:0] px_q;
  logic [Y_W-1:0] py_q;
  logic           pos_changed;
  dir_t           dir_cnt;
  dir_t           dir_issue;

  assign pos_changed = (player_x != px_q) | (player_y != py_q);

  // A moved sprite starts a new pass at UP in the very same cycle
  assign dir_issue = pos_changed ? DIR_UP : dir_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      px_q    <= '0;
      py_q    <= '0;
      dir_cnt <= DIR_UP;
    end else begin
      px_q    <= player_x;
      py_q    <= player_y;
      dir_cnt <= dir_t'(dir_issue + 2'd1);
    end
  end

  // ==============================
  // Stage A and stage B
  // ==============================
  logic              a_vld;
  dir_t              a_dir;
  logic              a_edge;
  logic              a_touch;
  logic [DIST_W-1:0] a_rem;
  logic              b_vld;
  dir_t              b_dir;
  logic              b_edge;
  logic              b_touch;
  logic [DIST_W-1:0] b_rem;
  logic              wb_en;
  logic              b_blocked;
  logic [DIST_W-1:0] b_dist;

  always_ff @(posedge clk) begin
    if (rst) begin
      a_vld     <= 1'b0;
      b_vld     <= 1'b0;
      scan_addr <= '0;
    end else begin
      a_vld <= 1'b1;
      // Work already in flight belongs to the old position and is dropped
      b_vld <= a_vld & ~pos_changed;
      if (at_edge[dir_issue]) begin
        scan_addr <= '0;
      end else begin
        case (dir_issue)
          DIR_UP:    scan_addr <= base - MAP_AW'(NUM_COL);
          DIR_DOWN:  scan_addr <= base + MAP_AW'(NUM_COL);
          DIR_LEFT:  scan_addr <= base - 1'b1;
          DIR_RIGHT: scan_addr <= base + 1'b1;
          default:   scan_addr <= '0;
        endcase
      end
    end
  end

  // Context rides along with the address, then with the memory data
  always_ff @(posedge clk) begin
    a_dir   <= dir_issue;
    a_edge  <= at_edge[dir_issue];
    a_touch <= touch[dir_issue];
    a_rem   <= rem[dir_issue];
    b_dir   <= a_dir;
    b_edge  <= a_edge;
    b_touch <= a_touch;
    b_rem   <= a_rem;
  end

  assign wb_en     = b_vld & ~pos_changed;
  assign b_blocked = b_edge | (scan_data != '0);
  assign b_dist    = b_blocked ? b_rem : MAX_DIST;

  // One direction is written back per clock
  always_ff @(posedge clk) begin
    if (rst) begin
      obstacles  <= '0;
      dist_up    <= MAX_DIST;
      dist_down  <= MAX_DIST;
      dist_left  <= MAX_DIST;
      dist_right <= MAX_DIST;
    end else if (wb_en) begin
      obstacles[b_dir] <= b_blocked & b_touch;
      case (b_dir)
        DIR_UP:    dist_up    <= b_dist;
        DIR_DOWN:  dist_down  <= b_dist;
        DIR_LEFT:  dist_left  <= b_dist;
        default:   dist_right <= b_dist;
      endcase
    end
  end

  // ==============================
  // Fresh flag
  // ==============================
  logic [1:0] wb_cnt;
  logic       fresh_q;

  // Four write-backs after a restart cover every direction once
  always_ff @(posedge clk) begin
    if (rst || pos_changed) begin
      wb_cnt  <= '0;
      fresh_q <= 1'b0;
    end else if (wb_en && !fresh_q) begin
      wb_cnt <= wb_cnt + 1'b1;
      if (wb_cnt == 2'd3) begin
        fresh_q <= 1'b1;
      end
    end
  end

  // Drop at once on a move so stale distances are never used
  assign scan_fresh = fresh_q & ~pos_changed;

endmodule

// File: hdl/player_motion.sv
module player_motion
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              pos_wr,
  input  logic [X_W-1:0]    pos_x,
  input  logic [Y_W-1:0]    pos_y,
  input  logic              move_req,
  input  dir_t              move_dir,
  input  logic [STEP_W-1:0] move_step,
  output logic              move_ready,
  output logic [X_W-1:0]    player_x,
  output logic [Y_W-1:0]    player_y,
  output logic              busy,
  input  logic [DIST_W-1:0] dist_up,
  input  logic [DIST_W-1:0] dist_down,
  input  logic [DIST_W-1:0] dist_left,
  input  logic [DIST_W-1:0] dist_right,
  input  logic              scan_fresh,
  output logic              move_done,
  output logic [STEP_W-1:0] applied_step,
  output logic              blocked
);

  typedef enum logic [1:0] {
    ST_IDLE, ST_WAIT_FRESH, ST_APPLY
  } state_t;

  state_t            state;
  dir_t              req_dir;
  logic [STEP_W-1:0] req_step;
  logic [DIST_W-1:0] dir_dist;
  logic [STEP_W-1:0] clamp_step;
  logic              clamp_blk;

  assign move_ready = (state == ST_IDLE);
  assign busy       = (state != ST_IDLE);
  assign move_done  = (state == ST_APPLY);

  // Free distance in the requested direction
  always_comb begin
    case (req_dir)
      DIR_UP:   dir_dist = dist_up;
      DIR_DOWN: dir_dist = dist_down;
      DIR_LEFT: dir_dist = dist_left;
      default:  dir_dist = dist_right;
    endcase
  end

  // A step longer than the free distance is cut back and flagged
  // Whenever the cut applies the distance is below the step, so it fits
  always_comb begin
    if (DIST_W'(req_step) > dir_dist) begin
      clamp_step = dir_dist[STEP_W-1:0];
      clamp_blk  = 1'b1;
    end else begin
      clamp_step = req_step;
      clamp_blk  = 1'b0;
    end
  end

  // ==============================
  // Move FSM
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      player_x <= '0;
      player_y <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pos_wr) begin
            player_x <= pos_x;
            player_y <= pos_y;
          end else if (move_req) begin
            state <= ST_WAIT_FRESH;
          end
        end
        // Hold until the scan has a complete pass for this position
        ST_WAIT_FRESH: if (scan_fresh) state <= ST_APPLY;
        ST_APPLY: begin
          case (req_dir)
            DIR_UP:   player_y <= player_y - Y_W'(applied_step);
            DIR_DOWN: player_y <= player_y + Y_W'(applied_step);
            DIR_LEFT: player_x <= player_x - X_W'(applied_step);
            default:  player_x <= player_x + X_W'(applied_step);
          endcase
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command and outcome are captured at the hand-over points
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && move_req) begin
      req_dir  <= move_dir;
      req_step <= move_step;
    end
    if ((state == ST_WAIT_FRESH) && scan_fresh) begin
      applied_step <= clamp_step;
      blocked      <= clamp_blk;
    end
  end

endmodule

// File: hdl/tile_game_top.sv
module tile_game_top
  import tile_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [WB_AW-1:0] wb_adr,
  input  logic [WB_DW-1:0] wb_dat_w,
  output logic [WB_DW-1:0] wb_dat_r,
  output logic             wb_ack
);

  // Bus side
  logic              move_ready;
  logic [WB_DW-1:0]  rd_data;
  reg_sel_t          rd_sel;
  logic              map_we;
  logic [MAP_AW-1:0] map_addr;
  logic [TILE_W-1:0] map_wdata;
  logic [TILE_W-1:0] map_rdata;

  // Commands into motion
  logic              pos_wr;
  logic [X_W-1:0]    pos_x;
  logic [Y_W-1:0]    pos_y;
  logic              move_req;
  dir_t              move_dir;
  logic [STEP_W-1:0] move_step;

  // Scan results and motion state
  logic [MAP_AW-1:0] scan_addr;
  logic [TILE_W-1:0] scan_data;
  logic [3:0]        obstacles;
  logic [DIST_W-1:0] dist_up;
  logic [DIST_W-1:0] dist_down;
  logic [DIST_W-1:0] dist_left;
  logic [DIST_W-1:0] dist_right;
  logic              scan_fresh;
  logic [X_W-1:0]    player_x;
  logic [Y_W-1:0]    player_y;
  logic              busy;
  logic              move_done;
  logic [STEP_W-1:0] applied_step;
  logic              blocked;

  wb_reg_decode i_decode (.*);

  tile_map_ram i_map (
    .clk, .a_we(map_we), .a_addr(map_addr), .a_wdata(map_wdata), .a_rdata(map_rdata),
    .b_addr(scan_addr), .b_rdata(scan_data)
  );

  obstacle_scan i_scan (.*);

  player_motion i_motion (.*);

  move_result i_result (.*);

endmodule

// File: hdl/tile_map_ram.sv
module tile_map_ram
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              a_we,
  input  logic [MAP_AW-1:0] a_addr,
  input  logic [TILE_W-1:0] a_wdata,
  output logic [TILE_W-1:0] a_rdata,
  input  logic [MAP_AW-1:0] b_addr,
  output logic [TILE_W-1:0] b_rdata
);

  logic [TILE_W-1:0] mem [MAP_DEPTH];

  // Clear pointer walks the whole map once, one tile per clock
  logic [MAP_AW-1:0] clr_addr = '0;
  logic              clr_busy;

  assign clr_busy = (clr_addr != MAP_AW'(MAP_DEPTH));

  // Host writes are dropped while the clear sweep is still running
  always_ff @(posedge clk) begin
    if (clr_busy) begin
      mem[clr_addr] <= '0;
      clr_addr      <= clr_addr + 1'b1;
    end else if (a_we && (a_addr < MAP_AW'(MAP_DEPTH))) begin
      mem[a_addr] <= a_wdata;
    end
  end

  // Both ports read with one cycle of latency
  // Addresses past the last tile read back as empty
  always_ff @(posedge clk) begin
    a_rdata <= (a_addr < MAP_AW'(MAP_DEPTH)) ? mem[a_addr] : '0;
    b_rdata <= (b_addr < MAP_AW'(MAP_DEPTH)) ? mem[b_addr] : '0;
  end

endmodule

// File: hdl/tile_pkg.sv
package tile_pkg;

  // ==============================
  // Map and sprite geometry
  // ==============================
  localparam int NUM_ROW    = 11;
  localparam int NUM_COL    = 19;
  localparam int TILE_PX    = 64;
  localparam int TILE_SHIFT = 6;
  localparam int SPRITE_W   = 32;
  localparam int SPRITE_H   = 64;
  localparam int MAP_DEPTH  = NUM_ROW * NUM_COL;
  localparam int MAP_AW     = 8;
  localparam int TILE_W     = 2;

  // Pixel coordinates and the tile row/column taken from them
  localparam int X_W   = 11;
  localparam int Y_W   = 10;
  localparam int ROW_W = Y_W - TILE_SHIFT;
  localparam int COL_W = X_W - TILE_SHIFT;

  // Distances cover one tile plus the all-ones "nothing there" value
  localparam int DIST_W = TILE_SHIFT + 1;
  localparam logic [DIST_W-1:0] MAX_DIST = 7'd127;
  localparam int STEP_W = 6;

  // ==============================
  // Wishbone register map
  // ==============================
  localparam int WB_DW       = 32;
  localparam int WB_AW       = 10;
  localparam int MAP_ADR_BIT = 9;
  localparam logic [MAP_ADR_BIT-1:0] ADR_POS    = 9'd0;
  localparam logic [MAP_ADR_BIT-1:0] ADR_MOVE   = 9'd1;
  localparam logic [MAP_ADR_BIT-1:0] ADR_STATUS = 9'd2;
  localparam logic [MAP_ADR_BIT-1:0] ADR_DIST   = 9'd3;

  // Direction code, also the bit index into the obstacle flags
  typedef enum logic [1:0] {
    DIR_UP    = 2'd0,
    DIR_DOWN  = 2'd1,
    DIR_LEFT  = 2'd2,
    DIR_RIGHT = 2'd3
  } dir_t;

  // Read select handed from the bus decoder to the read mux
  typedef enum logic [2:0] {
    REG_POS, REG_MOVE, REG_STATUS, REG_DIST, REG_MAP, REG_NONE
  } reg_sel_t;

endpackage

// File: hdl/wb_reg_decode.sv
module wb_reg_decode
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [WB_AW-1:0]  wb_adr,
  input  logic [WB_DW-1:0]  wb_dat_w,
  output logic [WB_DW-1:0]  wb_dat_r,
  output logic              wb_ack,
  input  logic              move_ready,
  input  logic [WB_DW-1:0]  rd_data,
  output logic              map_we,
  output logic [MAP_AW-1:0] map_addr,
  output logic [TILE_W-1:0] map_wdata,
  output logic              pos_wr,
  output logic [X_W-1:0]    pos_x,
  output logic [Y_W-1:0]    pos_y,
  output logic              move_req,
  output dir_t              move_dir,
  output logic [STEP_W-1:0] move_step,
  output reg_sel_t          rd_sel
);

  reg_sel_t sel;
  logic     req;
  logic     motion_wr;
  logic     go;

  // ==============================
  // Address classification
  // ==============================
  always_comb begin
    if (wb_adr[MAP_ADR_BIT]) begin
      sel = REG_MAP;
    end else begin
      case (wb_adr[MAP_ADR_BIT-1:0])
        ADR_POS:    sel = REG_POS;
        ADR_MOVE:   sel = REG_MOVE;
        ADR_STATUS: sel = REG_STATUS;
        ADR_DIST:   sel = REG_DIST;
        default:    sel = REG_NONE;
      endcase
    end
  end

  // A new access is only seen outside the ack cycle, so the host
  // holding stb across the ack does not start a second access
  assign req = wb_cyc & wb_stb & ~wb_ack;

  // Position and move writes must wait for the motion block to be idle
  assign motion_wr = wb_we & ((sel == REG_POS) | (sel == REG_MOVE));
  assign go        = req & (~motion_wr | move_ready);

  // Side effects fire once, in the cycle the access is accepted
  assign map_we   = go & wb_we & (sel == REG_MAP);
  assign pos_wr   = go & wb_we & (sel == REG_POS);
  assign move_req = go & wb_we & (sel == REG_MOVE);

  // Payload fields are taken straight off the held bus lines
  assign map_addr  = wb_adr[MAP_AW-1:0];
  assign map_wdata = wb_dat_w[TILE_W-1:0];
  assign pos_x     = wb_dat_w[X_W-1:0];
  assign pos_y     = wb_dat_w[16 +: Y_W];
  assign move_dir  = dir_t'(wb_dat_w[1:0]);
  assign move_step = wb_dat_w[8 +: STEP_W];

  // ==============================
  // Ack and read select
  // ==============================
  // The select is registered together with the ack, so the read mux
  // forms its word in the ack cycle, the same cycle in which the map
  // memory presents the tile addressed on the cycle before
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      rd_sel <= REG_NONE;
    end else begin
      wb_ack <= go;
      rd_sel <= (go & ~wb_we) ? sel : REG_NONE;
    end
  end

  // Outside a read ack the select is REG_NONE and the word is zero
  assign wb_dat_r = rd_data;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the tile game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_tile_game \
  -f sim.f -o tb_tile_game
./obj_dir/tb_tile_game | tee sim.log

if grep -q "^No errors$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: sim.f
hdl/tile_pkg.sv
hdl/wb_reg_decode.sv
hdl/tile_map_ram.sv
hdl/obstacle_scan.sv
hdl/player_motion.sv
hdl/move_result.sv
hdl/tile_game_top.sv
testbench/tb_tile_game.sv

// File: testbench/tb_tile_game.sv
module tb_tile_game
  import tile_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;
  // A full pass over the four neighbours ends 6 cycles after a position change
  localparam int SETTLE_CYCLES = 8;
  localparam logic [WB_AW-1:0] MAP_BASE = 10'h200;

  logic             clk;
  logic             rst;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic [WB_DW-1:0] wb_dat_r;
  logic             wb_ack;

  // Reference copy of the map and of the player state
  logic [1:0]  map_copy [MAP_DEPTH];
  int          mx;
  int          my;
  int          m_step;
  logic        m_blk;
  logic [7:0]  m_moves;
  logic [7:0]  m_blocked;
  logic [31:0] lcg_state;
  logic [31:0] pos_rd;
  logic [31:0] status_rd;
  logic [31:0] dist_rd;
  int          errors;
  int          checks;
  int          cycle_cnt;

  tile_game_top i_tile_game_top (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // ==============================
  // Checks and reference model
  // ==============================
  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic int next_rand(input int n);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]) % n;
  endfunction

  // Blocked, touching and remaining pixels for one side of the sprite
  function automatic logic [8:0] side_info(input int x, input int y, input int dir);
    int row;
    int col;
    int offx;
    int offy;
    int nb;
    int rem;
    bit at_edge;
    bit touch;
    bit blk;
    row  = y / TILE_PX;
    col  = x / TILE_PX;
    offx = x % TILE_PX;
    offy = y % TILE_PX;
    case (dir)
      DIR_UP: begin
        at_edge = (row == 0);
        nb      = (row - 1) * NUM_COL + col;
        touch   = (offy == 0);
        rem     = offy;
      end
      DIR_DOWN: begin
        at_edge = (row >= NUM_ROW - 1);
        nb      = (row + 1) * NUM_COL + col;
        touch   = (offy + SPRITE_H == TILE_PX);
        rem     = TILE_PX - (offy + SPRITE_H);
      end
      DIR_LEFT: begin
        at_edge = (col == 0);
        nb      = row * NUM_COL + col - 1;
        touch   = (offx == 0);
        rem     = offx;
      end
      default: begin
        at_edge = (col >= NUM_COL - 1);
        nb      = row * NUM_COL + col + 1;
        touch   = (offx + SPRITE_W == TILE_PX);
        rem     = TILE_PX - (offx + SPRITE_W);
      end
    endcase
    if (rem < 0) begin
      rem = 0;
    end
    // The neighbour only counts when the map goes on in that direction
    blk = at_edge;
    if (!at_edge) begin
      blk = (map_copy[nb] != 0);
    end
    return {blk, touch, 7'(rem)};
  endfunction

  function automatic logic [6:0] expected_dist(input int x, input int y, input int dir);
    logic [8:0] info;
    info = side_info(x, y, dir);
    return info[8] ? info[6:0] : MAX_DIST;
  endfunction

  function automatic logic [3:0] expected_obstacles(input int x, input int y);
    logic [8:0] info;
    logic [3:0] obs;
    for (int d = 0; d < 4; d++) begin
      info   = side_info(x, y, d);
      obs[d] = info[8] & info[7];
    end
    return obs;
  endfunction

  // ==============================
  // Bus tasks
  // ==============================
  // Tasks start and end 2 time units after a rising edge
  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
    logic got;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    got      = 1'b0;
    while (!got) begin
      @(posedge clk);
      #1;
      got = wb_ack;
    end
    rdat = wb_dat_r;
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
    logic [WB_DW-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  // Polls STATUS until the busy bit reads low
  task automatic wait_idle();
    logic [31:0] st;
    st = 32'h10;
    while (st[4]) begin
      wb_read(10'(ADR_STATUS), st);
    end
  endtask

  task automatic settle_scan();
    repeat (SETTLE_CYCLES) @(posedge clk);
    #2;
  endtask

  task automatic set_tile(input int addr, input int val);
    wb_write(MAP_BASE | 10'(addr), 32'(val));
    map_copy[addr] = 2'(val);
  endtask

  task automatic place_player(input int x, input int y);
    wb_write(10'(ADR_POS), (32'(y) << 16) | 32'(x));
    mx = x;
    my = y;
    settle_scan();
  endtask

  // Issues one move and advances the model by the clamp rule
  task automatic move_cmd(input int dir, input int step);
    int d;
    wb_write(10'(ADR_MOVE), (32'(step) << 8) | 32'(dir));
    d     = expected_dist(mx, my, dir);
    m_blk = (step > d);
    m_step = m_blk ? d : step;
    case (dir)
      DIR_UP:   my = my - m_step;
      DIR_DOWN: my = my + m_step;
      DIR_LEFT: mx = mx - m_step;
      default:  mx = mx + m_step;
    endcase
    m_moves = m_moves + 8'd1;
    if (m_blk) begin
      m_blocked = m_blocked + 8'd1;
    end
  endtask

  // Reads POS, STATUS and DIST once the scan has settled
  task automatic check_all();
    logic [31:0] exp;
    settle_scan();
    wb_read(10'(ADR_POS), pos_rd);
    wb_read(10'(ADR_STATUS), status_rd);
    wb_read(10'(ADR_DIST), dist_rd);
    check_equal("pos", {6'd0, 10'(my), 5'd0, 11'(mx)}, pos_rd);
    exp = {m_moves, m_blocked, 2'd0, 6'(m_step), 2'd0, m_blk, 1'b0,
           expected_obstacles(mx, my)};
    check_equal("status", exp, status_rd);
    exp = {1'b0, expected_dist(mx, my, DIR_RIGHT), 1'b0, expected_dist(mx, my, DIR_LEFT),
           1'b0, expected_dist(mx, my, DIR_DOWN), 1'b0, expected_dist(mx, my, DIR_UP)};
    check_equal("dist", exp, dist_rd);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_map_access();
    logic [31:0] rd;
    int          addr [4];
    addr = '{5, 42, 100, 208};
    for (int i = 0; i < 4; i++) begin
      set_tile(addr[i], 1 + i % 3);
    end
    for (int i = 0; i < 4; i++) begin
      wb_read(MAP_BASE | 10'(addr[i]), rd);
      check_equal($sformatf("map[%0d]", addr[i]), 32'(1 + i % 3), rd);
    end
    // Tiles never written keep the value of the power-up clear
    wb_read(MAP_BASE | 10'd6, rd);
    check_equal("map[6]", 32'd0, rd);
    wb_read(MAP_BASE | 10'd150, rd);
    check_equal("map[150]", 32'd0, rd);
    for (int i = 0; i < 4; i++) begin
      set_tile(addr[i], 0);
    end
  endtask

  task automatic test_edge_blocking();
    place_player(0, 0);
    check_all();
    check_equal("obstacles", 32'h5, 32'(status_rd[3:0]));
    check_equal("dist_up", 32'd0, 32'(dist_rd[6:0]));
    check_equal("dist_left", 32'd0, 32'(dist_rd[22:16]));
    move_cmd(DIR_LEFT, 10);
    wait_idle();
    check_all();
    check_equal("player_x", 32'd0, 32'(pos_rd[10:0]));
    check_equal("last_blocked", 32'd1, 32'(status_rd[5]));
    check_equal("applied_step", 32'd0, 32'(status_rd[13:8]));
  endtask

  task automatic test_tile_clamp();
    // Right neighbour of tile row 1, column 1
    set_tile(NUM_COL + 2, 2);
    place_player(80, 64);
    check_all();
    check_equal("dist_right", 32'd16, 32'(dist_rd[30:24]));
    move_cmd(DIR_RIGHT, 30);
    wait_idle();
    check_all();
    check_equal("applied_step", 32'd16, 32'(status_rd[13:8]));
    check_equal("last_blocked", 32'd1, 32'(status_rd[5]));
    check_equal("player_x", 32'd96, 32'(pos_rd[10:0]));
    set_tile(NUM_COL + 2, 0);
  endtask

  task automatic test_free_move();
    place_player(200, 128);
    move_cmd(DIR_DOWN, 20);
    wait_idle();
    check_all();
    check_equal("applied_step", 32'd20, 32'(status_rd[13:8]));
    check_equal("last_blocked", 32'd0, 32'(status_rd[5]));
    check_equal("player_y", 32'd148, 32'(pos_rd[25:16]));
    check_equal("dist", 32'h7f7f7f7f, dist_rd);
  endtask

  task automatic test_random_walk();
    for (int i = 0; i < 30; i++) begin
      set_tile(next_rand(MAP_DEPTH), next_rand(4));
    end
    place_player(next_rand(1185), next_rand(641));
    for (int i = 0; i < 40; i++) begin
      move_cmd(next_rand(4), next_rand(64));
      wait_idle();
      check_all();
    end
  endtask

  // MOVE writes go out back to back and are acked only when motion is idle
  task automatic test_back_pressure();
    for (int i = 0; i < 12; i++) begin
      move_cmd(next_rand(4), next_rand(64));
    end
    wait_idle();
    check_all();
    check_equal("move_count", 32'(m_moves), 32'(status_rd[31:24]));
    check_equal("blocked_count", 32'(m_blocked), 32'(status_rd[23:16]));
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    lcg_state = 32'd81;
    mx        = 0;
    my        = 0;
    m_step    = 0;
    m_blk     = 1'b0;
    m_moves   = '0;
    m_blocked = '0;
    for (int i = 0; i < MAP_DEPTH; i++) begin
      map_copy[i] = '0;
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    // The map memory clears itself one tile per clock
    repeat (220) @(posedge clk);
    #2;
    test_map_access();
    test_edge_blocking();
    test_tile_clamp();
    test_free_move();
    test_random_walk();
    test_back_pressure();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
